// File: common/icachePkg.sv
package icachePkg;

	// Byte address and line geometry
	localparam int addrWidth = 48;

	typedef logic [43:0] lineAddrT;		// 16-byte line address
	typedef logic [127:0] tileT;		// One cache line
	typedef logic [95:0] windowT;		// Six 16-bit words
	typedef logic [3:0] epochT;			// Flush epoch
	typedef logic [2:0] stepT;			// PC step in 16-bit words

	// Memory command
	typedef logic [4:0] opmT;

	localparam opmT opmReady = 5'b00000;	// Idle bus
	localparam opmT opmReadTile = 5'b00111;	// Fetch one 16-byte line
	localparam opmT opmFlushIs = 5'b01000;	// Invalidate instruction side

	// Memory and fetch status
	typedef logic [1:0] okT;

	localparam okT okReady = 2'b00;		// Idle, may accept a command
	localparam okT okOk = 2'b01;		// Data valid
	localparam okT okHold = 2'b10;		// Busy, try again
	localparam okT okFault = 2'b11;		// Access failed

endpackage

// File: icache/fetchAddrGen.sv
module fetchAddrGen #(
	parameter int IndexBits = 6
)(
	input logic clock,
	input logic reset,
	input logic [icachePkg::addrWidth-1:0] pc,
	input logic hold,
	output icachePkg::lineAddrT lineEven,
	output icachePkg::lineAddrT lineOdd,
	output logic [icachePkg::addrWidth-1:0] fetchPc
);
	import icachePkg::*;

	localparam int LineBits = $bits(lineAddrT);
	localparam int LowBits = IndexBits + 1;		// Parity bit plus index

	logic [addrWidth-1:0] selPc;
	lineAddrT thisLine;
	lineAddrT nextLine;
	logic [LowBits:0] lowSum;		// Top bit is the carry into the tag part

	always_comb
	begin
		// Hold replays the PC already in flight
		selPc = hold ? fetchPc : pc;
		thisLine = selPc[addrWidth-1:4];

		// Next line, add split at the index boundary
		lowSum = {1'b0, thisLine[LowBits-1:0]} + 1'b1;
		nextLine[LowBits-1:0] = lowSum[LowBits-1:0];
		nextLine[LineBits-1:LowBits] = thisLine[LineBits-1:LowBits] + lowSum[LowBits];

		// Steer by line parity
		if (thisLine[0])
		begin
			lineOdd = thisLine;
			lineEven = nextLine;		// Following even line
		end
		else
		begin
			lineEven = thisLine;
			lineOdd = nextLine;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			fetchPc <= '0;
		else
			fetchPc <= selPc;		// Lines up with the bank read
	end

endmodule

// File: icache/fetchWindow.sv
module fetchWindow(
	input logic [icachePkg::addrWidth-1:0] fetchPc,
	input icachePkg::tileT dataEven,
	input icachePkg::tileT dataOdd,
	input logic hitEven,
	input logic hitOdd,
	input logic fault,
	input logic wxe,
	output icachePkg::windowT pcVal,
	output icachePkg::okT pcOk,
	output icachePkg::stepT pcStep
);
	import icachePkg::*;

	logic [255:0] linePair;		// PC line low, following line high
	logic [255:0] shifted;
	logic [15:0] word0;
	logic [15:0] word2;
	stepT ownStep;

	// 32-bit op prefix
	function automatic logic isLong(input logic [15:0] word);
		return word[15:13] == 3'b111;
	endfunction

	// 32-bit op with the bundle flag set
	function automatic logic isWex(input logic [15:0] word);
		logic [3:0] sel;
		sel = word[12:9];
		return isLong(word)
			&& (sel inside {4'b1111, 4'b1110, 4'b1011, 4'b1010, 4'b0111, 4'b0101});
	endfunction

	always_comb
	begin
		// Odd PC line means the next line comes from the even bank
		if (fetchPc[4])
			linePair = {dataEven, dataOdd};
		else
			linePair = {dataOdd, dataEven};

		shifted = linePair >> {fetchPc[3:1], 4'b0000};		// Word offset into the pair
		pcVal = shifted[95:0];

		word0 = pcVal[15:0];
		word2 = pcVal[47:32];		// Second op of a bundle

		ownStep = isLong(word0) ? 3'd2 : 3'd1;

		// Two or three wide bundle
		if (wxe && isWex(word0))
			pcStep = isWex(word2) ? 3'd6 : 3'd4;
		else
			pcStep = ownStep;

		if (fault)
			pcOk = okFault;		// Only for the fill-done cycle
		else if (!hitEven || !hitOdd)
			pcOk = okHold;
		else
			pcOk = okOk;
	end

endmodule

// File: icache/flushEpoch.sv
module flushEpoch(
	input logic clock,
	input logic reset,
	input icachePkg::opmT opm,
	output icachePkg::epochT epoch
);
	import icachePkg::*;

	opmT opmStage1;		// First delay stage
	opmT opmStage2;		// Second delay stage
	logic flushEdge;
	logic bumpEpoch;

	// Leading edge only, a held FLUSHIS counts once
	assign flushEdge = (opmStage1 == opmFlushIs) && (opmStage2 != opmFlushIs);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			opmStage1 <= opmReady;
			opmStage2 <= opmReady;
			bumpEpoch <= 1'b0;
			epoch <= '0;
		end
		else
		begin
			opmStage1 <= opm;
			opmStage2 <= opmStage1;
			bumpEpoch <= flushEdge;

			// Every stored line now carries a stale epoch
			if (bumpEpoch)
				epoch <= epoch + 1'b1;		// Wraps
		end
	end

endmodule

// File: icache/l1InstCache.sv
module l1InstCache #(
	parameter int IndexBits = 6
)(
	input logic clock,
	input logic reset,
	input logic [icachePkg::addrWidth-1:0] pc,
	input logic hold,
	input logic wxe,
	input icachePkg::opmT opm,
	output icachePkg::windowT pcVal,
	output icachePkg::okT pcOk,
	output icachePkg::stepT pcStep,
	input icachePkg::okT memOk,
	input icachePkg::tileT memData,
	output icachePkg::opmT memOpm,
	output logic [icachePkg::addrWidth-1:0] memAddr
);
	import icachePkg::*;

	lineAddrT lineEven;
	lineAddrT lineOdd;
	logic [addrWidth-1:0] fetchPc;
	epochT epoch;
	lineAddrT reqEven;		// Line held in each bank's read register
	lineAddrT reqOdd;
	tileT dataEven;
	tileT dataOdd;
	logic hitEven;
	logic hitOdd;
	tileT fillData;
	logic fillEven;
	logic fillOdd;
	logic fault;

	fetchAddrGen #(.IndexBits(IndexBits)) addrGen0 (
		.clock(clock),
		.reset(reset),
		.pc(pc),
		.hold(hold),
		.lineEven(lineEven),
		.lineOdd(lineOdd),
		.fetchPc(fetchPc)
	);

	flushEpoch flush0 (
		.clock(clock),
		.reset(reset),
		.opm(opm),
		.epoch(epoch)
	);

	// Even 16-byte lines
	lineBank #(.IndexBits(IndexBits)) evenBank (
		.clock(clock),
		.reset(reset),
		.readLine(lineEven),
		.epoch(epoch),
		.fill(fillEven),
		.fillData(fillData),
		.lineData(dataEven),
		.reqLine(reqEven),
		.hit(hitEven)
	);

	// Odd 16-byte lines
	lineBank #(.IndexBits(IndexBits)) oddBank (
		.clock(clock),
		.reset(reset),
		.readLine(lineOdd),
		.epoch(epoch),
		.fill(fillOdd),
		.fillData(fillData),
		.lineData(dataOdd),
		.reqLine(reqOdd),
		.hit(hitOdd)
	);

	missFill #(.IndexBits(IndexBits)) fill0 (
		.clock(clock),
		.reset(reset),
		.hitEven(hitEven),
		.hitOdd(hitOdd),
		.reqEven(reqEven),
		.reqOdd(reqOdd),
		.memOk(memOk),
		.memData(memData),
		.memOpm(memOpm),
		.memAddr(memAddr),
		.fillData(fillData),
		.fillEven(fillEven),
		.fillOdd(fillOdd),
		.fault(fault)
	);

	fetchWindow window0 (
		.fetchPc(fetchPc),
		.dataEven(dataEven),
		.dataOdd(dataOdd),
		.hitEven(hitEven),
		.hitOdd(hitOdd),
		.fault(fault),
		.wxe(wxe),
		.pcVal(pcVal),
		.pcOk(pcOk),
		.pcStep(pcStep)
	);

endmodule

// File: icache/lineBank.sv
module lineBank #(
	parameter int IndexBits = 6
)(
	input logic clock,
	input logic reset,
	input icachePkg::lineAddrT readLine,
	input icachePkg::epochT epoch,
	input logic fill,
	input icachePkg::tileT fillData,
	output icachePkg::tileT lineData,
	output icachePkg::lineAddrT reqLine,
	output logic hit
);
	import icachePkg::*;

	localparam int Entries = 1 << IndexBits;

	tileT dataMem [Entries];		// Line data
	lineAddrT lineMem [Entries];	// Full line address as tag
	epochT epochMem [Entries];		// Epoch at fill time
	logic [Entries-1:0] validBits;

	logic [IndexBits-1:0] readIdx;
	logic [IndexBits-1:0] fillIdx;
	lineAddrT storedLine;
	epochT storedEpoch;
	logic storedValid;

	// Bit 0 picks the bank, index sits just above it
	assign readIdx = readLine[IndexBits:1];
	assign fillIdx = reqLine[IndexBits:1];

	// Storage arrays and read registers
	always_ff @(posedge clock)
	begin
		lineData <= dataMem[readIdx];
		storedLine <= lineMem[readIdx];
		storedEpoch <= epochMem[readIdx];

		if (fill)
		begin
			dataMem[fillIdx] <= fillData;
			lineMem[fillIdx] <= reqLine;
			epochMem[fillIdx] <= epoch;		// Tagged with the live epoch
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			validBits <= '0;
			storedValid <= 1'b0;
			reqLine <= '0;
		end
		else
		begin
			storedValid <= validBits[readIdx];
			reqLine <= readLine;		// Line this read was for

			if (fill)
				validBits[fillIdx] <= 1'b1;
		end
	end

	// Stale epoch after a flush counts as a miss
	assign hit = storedValid && (storedLine == reqLine) && (storedEpoch == epoch);

	// Fill sequencer stays quiet while the bank is held in reset
	noFillInReset: assert property (@(posedge clock) reset |-> !fill);

endmodule

// File: icache/missFill.sv
module missFill #(
	parameter int IndexBits = 6
)(
	input logic clock,
	input logic reset,
	input logic hitEven,
	input logic hitOdd,
	input icachePkg::lineAddrT reqEven,
	input icachePkg::lineAddrT reqOdd,
	input icachePkg::okT memOk,
	input icachePkg::tileT memData,
	output icachePkg::opmT memOpm,
	output logic [icachePkg::addrWidth-1:0] memAddr,
	output icachePkg::tileT fillData,
	output logic fillEven,
	output logic fillOdd,
	output logic fault
);
	import icachePkg::*;

	okT memOkR;			// Registered memory status
	tileT memDataR;		// Registered memory data
	logic latchEven;	// Fill in flight for the even bank
	logic latchOdd;		// Fill in flight for the odd bank
	logic fillDone;		// Line written, waiting for memory idle
	logic missEven;
	logic missOdd;
	logic takeData;

	assign missEven = !hitEven;
	assign missOdd = !hitOdd;

	// Memory answered the outstanding read
	assign takeData = (latchEven || latchOdd) && !fillDone
		&& ((memOkR == okOk) || (memOkR == okFault));

	// Memory data in, line out to the banks
	always_ff @(posedge clock)
	begin
		memDataR <= memData;
		if (takeData)
			fillData <= memDataR;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			memOkR <= okReady;
			latchEven <= 1'b0;
			latchOdd <= 1'b0;
			fillDone <= 1'b0;
			memOpm <= opmReady;
			memAddr <= '0;
			fillEven <= 1'b0;
			fillOdd <= 1'b0;
			fault <= 1'b0;
		end
		else
		begin
			memOkR <= memOk;
			fillEven <= 1'b0;		// Strobes last one cycle
			fillOdd <= 1'b0;
			fault <= 1'b0;

			if (!latchEven && !latchOdd)
			begin
				memOpm <= opmReady;
				// Even bank wins when both miss
				if ((missEven || missOdd) && (memOkR == okReady))
				begin
					latchEven <= missEven;
					latchOdd <= !missEven;
					memOpm <= opmReadTile;
					memAddr <= {missEven ? reqEven : reqOdd, 4'b0000};
				end
			end
			else if (!fillDone)
			begin
				// Keep the read up through okHold
				if (takeData)
				begin
					fillEven <= latchEven;
					fillOdd <= latchOdd;
					fault <= (memOkR == okFault);		// Faulted line still written
					memOpm <= opmReady;
					fillDone <= 1'b1;
				end
			end
			else
			begin
				memOpm <= opmReady;
				// Memory idle again
				// A bank that still misses restarts from the top
				if (memOkR == okReady)
				begin
					latchEven <= 1'b0;
					latchOdd <= 1'b0;
					fillDone <= 1'b0;
				end
			end
		end
	end

	// One bank at a time
	oneLatch: assert property (@(posedge clock) disable iff (reset)
		!(latchEven && latchOdd));

	// Only read and idle codes on the fill port
	legalOpm: assert property (@(posedge clock) disable iff (reset)
		(memOpm == opmReady) || (memOpm == opmReadTile));

	// Core hold keeps the target entry fixed until the write
	evenIdxHeld: assert property (@(posedge clock) disable iff (reset)
		(latchEven && !fillDone) |=> $stable(reqEven[IndexBits:1]));
	oddIdxHeld: assert property (@(posedge clock) disable iff (reset)
		(latchOdd && !fillDone) |=> $stable(reqOdd[IndexBits:1]));

endmodule

// File: run.sh
#!/bin/sh
# Build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module icacheTb -f src.f -o icacheSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/icacheSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
	exit 1
fi
if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then
	echo "Simulation ended without a result line"
	exit 1
fi
exit 0

// File: src.f
common/icachePkg.sv
icache/fetchAddrGen.sv
icache/flushEpoch.sv
icache/lineBank.sv
icache/missFill.sv
icache/fetchWindow.sv
icache/l1InstCache.sv
tests/tileMemory.sv
tests/icacheTb.sv

// File: tests/icacheTb.sv
module icacheTb;
	import icachePkg::*;

	localparam int IndexBits = 6;
	localparam int ClockPeriod = 10;
	localparam int FetchLimit = 64;		// Cycles, two worst-case fills with margin
	localparam int ColdCount = 12;
	localparam int RandomCount = 40;
	localparam int FetchCount = 2 * ColdCount + RandomCount + 12 + 3 + 1;
	localparam int WatchdogTime = (FetchCount + 8) * FetchLimit * ClockPeriod;
	localparam lineAddrT FaultLine = 44'h0d30;

	logic clock;
	logic reset;
	logic [addrWidth-1:0] pc;
	logic hold;
	logic wxe;
	opmT opm;
	windowT pcVal;
	okT pcOk;
	stepT pcStep;
	okT memOk;
	tileT memData;
	opmT memOpm;
	logic [addrWidth-1:0] memAddr;
	int readCount;

	logic [31:0] lfsrState;
	int errorCount;
	int checkCount;
	int testErrors;		// errorCount when the test started
	int testsRun;
	int testsFailed;
	string testName;
	logic sawFault;

	// Finished fetches waiting for the compare process
	logic [addrWidth-1:0] pcQ [$];
	logic wxeQ [$];
	windowT valQ [$];
	stepT stepQ [$];

	l1InstCache #(.IndexBits(IndexBits)) dut0 (
		.clock(clock),
		.reset(reset),
		.pc(pc),
		.hold(hold),
		.wxe(wxe),
		.opm(opm),
		.pcVal(pcVal),
		.pcOk(pcOk),
		.pcStep(pcStep),
		.memOk(memOk),
		.memData(memData),
		.memOpm(memOpm),
		.memAddr(memAddr)
	);

	tileMemory #(.FaultLine(FaultLine)) mem0 (
		.clock(clock),
		.reset(reset),
		.memOpm(memOpm),
		.memAddr(memAddr),
		.memOk(memOk),
		.memData(memData),
		.readCount(readCount)
	);

	always #(ClockPeriod / 2) clock = ~clock;

	// Same word contents as the memory model
	function automatic logic [15:0] wordAt(input logic [31:0] wordAddr);
		logic [31:0] h;
		logic [15:0] word;
		h = wordAddr * 32'h9e3779b1;
		h = h ^ (h >> 15);
		h = h * 32'h85ebca6b;
		h = h ^ (h >> 13);
		word = h[15:0];
		if (h[16])
			word[15:13] = 3'b111;
		return word;
	endfunction

	// 32-bit op with W set
	function automatic logic bundleFlag(input logic [15:0] word);
		if (word[15:13] != 3'b111)
			return 1'b0;
		case (word[12:9])
			4'b1111, 4'b1110, 4'b1011, 4'b1010, 4'b0111, 4'b0101:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	// Expected {step, window} for one fetch
	function automatic logic [98:0] refFetch(input logic [addrWidth-1:0] fetchAddr,
		input logic wideOn);
		windowT window;
		stepT step;
		logic [31:0] wordAddr;
		wordAddr = fetchAddr[32:1];
		for (int i = 0; i < 6; i++)
			window[16*i +: 16] = wordAt(wordAddr + i);
		if (wideOn && bundleFlag(window[15:0]))
			step = bundleFlag(window[47:32]) ? 3'd6 : 3'd4;
		else if (window[15:13] == 3'b111)
			step = 3'd2;
		else
			step = 3'd1;
		return {step, window};
	endfunction

	function automatic logic [31:0] takeBits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++)
		begin
			bits = {bits[30:0], lfsrState[0]};
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
		end
		return bits;
	endfunction

	task automatic checkValue(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		checkCount++;
		if (expected !== actual)
		begin
			errorCount++;
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
		end
	endtask

	always @(negedge clock)
	begin : compareResults
		logic [98:0] expected;
		logic [addrWidth-1:0] fetchAddr;
		logic wideOn;
		windowT gotVal;
		stepT gotStep;
		while (pcQ.size() > 0)
		begin
			fetchAddr = pcQ.pop_front();
			wideOn = wxeQ.pop_front();
			gotVal = valQ.pop_front();
			gotStep = stepQ.pop_front();
			expected = refFetch(fetchAddr, wideOn);
			checkValue($sformatf("%s pcVal pc=%h", testName, fetchAddr), expected[95:0], gotVal);
			checkValue($sformatf("%s pcStep pc=%h wxe=%0b", testName, fetchAddr, wideOn),
				expected[98:96], gotStep);
		end
	end

	// Core holds until the cache shows okOk
	task automatic waitForOk(input logic [addrWidth-1:0] fetchAddr, output logic done);
		int waited;
		waited = 0;
		done = 1'b0;
		sawFault = 1'b0;
		while (!done && waited < FetchLimit)
		begin
			@(negedge clock);
			if (pcOk == okFault)
				sawFault = 1'b1;
			if (pcOk == okOk)
				done = 1'b1;
			else
				waited++;
		end
		if (!done)
		begin
			errorCount++;
			$display("Fetch at pc %h did not reach okOk within %0d cycles", fetchAddr, FetchLimit);
		end
	endtask

	task automatic fetchOne(input logic [addrWidth-1:0] fetchAddr, input logic wideOn);
		logic done;
		@(posedge clock);
		pc <= fetchAddr;
		wxe <= wideOn;
		hold <= 1'b0;
		@(posedge clock);
		hold <= 1'b1;		// Replay from here on
		waitForOk(fetchAddr, done);
		if (done)
		begin
			pcQ.push_back(fetchAddr);
			wxeQ.push_back(wideOn);
			valQ.push_back(pcVal);
			stepQ.push_back(pcStep);
		end
	endtask

	task automatic startTest(input string name);
		testName = name;
		testErrors = errorCount;
	endtask

	task automatic finishTest();
		while (pcQ.size() > 0)
			@(posedge clock);		// Compare process drains at negedge
		testsRun++;
		if (errorCount == testErrors)
			$display("test %s ok", testName);
		else
		begin
			testsFailed++;
			$display("test %s had %0d error(s)", testName, errorCount - testErrors);
		end
	endtask

	initial
	begin : stimulus
		int countBefore;
		logic done;
		logic [31:0] bits;
		clock = 1'b0;
		reset = 1'b1;
		pc = '0;
		hold = 1'b0;
		wxe = 1'b0;
		opm = opmReady;
		lfsrState = 32'hcf7996d4;
		errorCount = 0;
		checkCount = 0;
		testsRun = 0;
		testsFailed = 0;
		repeat (4) @(posedge clock);
		reset <= 1'b0;

		startTest("coldSequential");
		for (int i = 0; i < ColdCount; i++)
			fetchOne(48'(6 * i), 1'b0);
		finishTest();

		// Same PCs again, all lines still resident
		startTest("refetchNoReads");
		countBefore = readCount;
		for (int i = 0; i < ColdCount; i++)
			fetchOne(48'(6 * i), 1'b1);
		checkValue("refetchNoReads readCount", countBefore, readCount);
		finishTest();

		startTest("randomStep");
		for (int i = 0; i < RandomCount; i++)
		begin
			bits = takeBits(12);
			fetchOne(48'h4000 + {bits[11:1], 1'b0}, i[0]);
		end
		finishTest();

		// Last 10 bytes of an even and an odd line, then across the index wrap
		startTest("lineEnd");
		for (int i = 0; i < 5; i++)
		begin
			fetchOne(48'hc46 + 2 * i, i[0]);
			fetchOne(48'hc56 + 2 * i, i[0]);
		end
		fetchOne(48'h7fa, 1'b1);
		fetchOne(48'h7fe, 1'b0);
		finishTest();

		startTest("flushRefetch");
		@(posedge clock);
		opm <= opmFlushIs;
		@(posedge clock);
		opm <= opmReady;
		repeat (4) @(posedge clock);		// Epoch moves about 3 cycles after the command
		waitForOk(48'h7fe, done);			// Held PC refills first
		countBefore = readCount;
		fetchOne(48'hc48, 1'b0);
		fetchOne(48'hc58, 1'b1);
		checkValue("flushRefetch new reads", 1'b1, readCount > countBefore);
		finishTest();

		startTest("faultLine");
		fetchOne({FaultLine, 4'h0}, 1'b0);
		checkValue("faultLine okFault seen", 1'b1, sawFault);
		finishTest();

		$display("tests %0d, failing tests %0d, checks %0d, errors %0d",
			testsRun, testsFailed, checkCount, errorCount);
		if (errorCount == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	initial
	begin : watchdog
		#(WatchdogTime);
		$display("Watchdog expired after %0d time units, the run did not finish", WatchdogTime);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: tests/tileMemory.sv
module tileMemory #(
	parameter icachePkg::lineAddrT FaultLine = 44'h0
)(
	input logic clock,
	input logic reset,
	input icachePkg::opmT memOpm,
	input logic [icachePkg::addrWidth-1:0] memAddr,
	output icachePkg::okT memOk,
	output icachePkg::tileT memData,
	output int readCount
);
	import icachePkg::*;

	logic [31:0] lfsrState;
	lineAddrT lineAddr;		// Line being read
	logic [3:0] holdLeft;	// Extra okHold cycles still due
	logic busy;
	logic answered;			// Data shown, waiting for opm to drop

	// Word contents from the word address
	function automatic logic [15:0] wordAt(input logic [31:0] wordAddr);
		logic [31:0] h;
		logic [15:0] word;
		h = wordAddr * 32'h9e3779b1;
		h = h ^ (h >> 15);
		h = h * 32'h85ebca6b;
		h = h ^ (h >> 13);
		word = h[15:0];
		if (h[16])
			word[15:13] = 3'b111;		// Favour 32-bit ops
		return word;
	endfunction

	function automatic tileT tileAt(input lineAddrT line);
		tileT tile;
		logic [31:0] base;
		base = {line[28:0], 3'b000};	// Low 32 bits of the word address
		for (int j = 0; j < 8; j++)
			tile[16*j +: 16] = wordAt(base + j);
		return tile;
	endfunction

	// Galois LFSR, one step per bit
	function automatic logic [31:0] takeBits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++)
		begin
			bits = {bits[30:0], lfsrState[0]};
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
		end
		return bits;
	endfunction

	always @(posedge clock)
	begin
		if (reset)
		begin
			lfsrState = 32'hcf7996d4;
			memOk <= okReady;
			memData <= '0;
			readCount <= 0;
			lineAddr <= '0;
			holdLeft <= '0;
			busy <= 1'b0;
			answered <= 1'b0;
		end
		else if (answered)
		begin
			if (memOpm == opmReady)
			begin
				memOk <= okReady;		// Idle again
				answered <= 1'b0;
			end
		end
		else if (busy)
		begin
			if (holdLeft == 0)
			begin
				memOk <= (lineAddr == FaultLine) ? okFault : okOk;
				memData <= tileAt(lineAddr);		// Data also on a fault
				busy <= 1'b0;
				answered <= 1'b1;
			end
			else
				holdLeft <= holdLeft - 1'b1;
		end
		else if (memOpm == opmReadTile)
		begin
			lineAddr <= memAddr[addrWidth-1:4];
			holdLeft <= 4'(takeBits(3));	// 1 to 8 okHold cycles
			memOk <= okHold;
			busy <= 1'b1;
			readCount <= readCount + 1;
		end
	end

endmodule
